// ==== sources.f ====
+incdir+include
+incdir+dv
hdl/id_pkg.sv
hdl/id_ifs.sv
hdl/id_pipe_reg.sv
hdl/inst_decoder.sv
hdl/operand_bypass.sv
hdl/reg_file.sv
hdl/id_stage.sv
dv/tb_id_stage.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build tb_id_stage with Verilator, run it, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module tb_id_stage -o tb_id_stage
	./obj_dir/tb_id_stage | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "test did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/id_tests.svh ====
`ifndef ID_TESTS_SVH
`define ID_TESTS_SVH

// flags are {src1_is_sa, ovf_check, load_op, mem_we}
task automatic decode_case(input string name, input logic [31:0] inst,
                           input id_pkg::alu_op_e alu, input logic [4:0] dest,
                           input logic src2_imm, input logic [31:0] imm,
                           input logic [3:0] flags);
    issue_inst(inst, last_pc + 32'd4);
    wait_out_valid();
    check_eq(name, "out_pc", last_pc, out_pc);
    check_eq(name, "alu_op", 32'(alu), 32'(out_alu_op));
    check_eq(name, "dest", 32'(dest), 32'(out_dest));
    check_eq(name, "src2_is_imm", 32'(src2_imm), 32'(out_src2_is_imm));
    if (src2_imm || flags[3])
        check_eq(name, "imm_value", imm, out_imm_value);
    check_eq(name, "flags", 32'(flags),
             32'({out_src1_is_sa, out_ovf_check, out_load_op, out_mem_we}));
    check_eq(name, "exc", 32'd0, 32'(out_exc));
endtask

task automatic decode_all();
    decode_case("addu", r_word(id_pkg::fn_addu, 5'd1, 5'd2, 5'd3, 5'd0),
                id_pkg::alu_add, 5'd3, 1'b0, 32'h0, 4'b0000);
    decode_case("add", r_word(id_pkg::fn_add, 5'd1, 5'd2, 5'd4, 5'd0),
                id_pkg::alu_add, 5'd4, 1'b0, 32'h0, 4'b0100);
    decode_case("subu", r_word(id_pkg::fn_subu, 5'd1, 5'd2, 5'd5, 5'd0),
                id_pkg::alu_sub, 5'd5, 1'b0, 32'h0, 4'b0000);
    decode_case("sub", r_word(id_pkg::fn_sub, 5'd1, 5'd2, 5'd6, 5'd0),
                id_pkg::alu_sub, 5'd6, 1'b0, 32'h0, 4'b0100);
    decode_case("slt", r_word(id_pkg::fn_slt, 5'd1, 5'd2, 5'd7, 5'd0),
                id_pkg::alu_slt, 5'd7, 1'b0, 32'h0, 4'b0000);
    decode_case("sltu", r_word(id_pkg::fn_sltu, 5'd1, 5'd2, 5'd8, 5'd0),
                id_pkg::alu_sltu, 5'd8, 1'b0, 32'h0, 4'b0000);
    decode_case("and", r_word(id_pkg::fn_and, 5'd1, 5'd2, 5'd9, 5'd0),
                id_pkg::alu_and, 5'd9, 1'b0, 32'h0, 4'b0000);
    decode_case("or", r_word(id_pkg::fn_or, 5'd1, 5'd2, 5'd10, 5'd0),
                id_pkg::alu_or, 5'd10, 1'b0, 32'h0, 4'b0000);
    decode_case("xor", r_word(id_pkg::fn_xor, 5'd1, 5'd2, 5'd11, 5'd0),
                id_pkg::alu_xor, 5'd11, 1'b0, 32'h0, 4'b0000);
    decode_case("nor", r_word(id_pkg::fn_nor, 5'd1, 5'd2, 5'd12, 5'd0),
                id_pkg::alu_nor, 5'd12, 1'b0, 32'h0, 4'b0000);
    // shift amount comes out on the immediate bus
    decode_case("sll", r_word(id_pkg::fn_sll, 5'd0, 5'd2, 5'd13, 5'd5),
                id_pkg::alu_sll, 5'd13, 1'b0, 32'h0000_0005, 4'b1000);
    decode_case("srl", r_word(id_pkg::fn_srl, 5'd0, 5'd2, 5'd14, 5'd7),
                id_pkg::alu_srl, 5'd14, 1'b0, 32'h0000_0007, 4'b1000);
    decode_case("sra", r_word(id_pkg::fn_sra, 5'd0, 5'd2, 5'd15, 5'd31),
                id_pkg::alu_sra, 5'd15, 1'b0, 32'h0000_001f, 4'b1000);
    decode_case("sllv", r_word(id_pkg::fn_sllv, 5'd1, 5'd2, 5'd16, 5'd0),
                id_pkg::alu_sll, 5'd16, 1'b0, 32'h0, 4'b0000);
    decode_case("srlv", r_word(id_pkg::fn_srlv, 5'd1, 5'd2, 5'd17, 5'd0),
                id_pkg::alu_srl, 5'd17, 1'b0, 32'h0, 4'b0000);
    decode_case("srav", r_word(id_pkg::fn_srav, 5'd1, 5'd2, 5'd18, 5'd0),
                id_pkg::alu_sra, 5'd18, 1'b0, 32'h0, 4'b0000);
    // immediate forms write rt
    decode_case("addiu", i_word(id_pkg::op_addiu, 5'd1, 5'd19, 16'hfff0),
                id_pkg::alu_add, 5'd19, 1'b1, 32'hffff_fff0, 4'b0000);
    decode_case("addi", i_word(id_pkg::op_addi, 5'd1, 5'd20, 16'h0010),
                id_pkg::alu_add, 5'd20, 1'b1, 32'h0000_0010, 4'b0100);
    decode_case("slti", i_word(id_pkg::op_slti, 5'd1, 5'd21, 16'h8000),
                id_pkg::alu_slt, 5'd21, 1'b1, 32'hffff_8000, 4'b0000);
    decode_case("sltiu", i_word(id_pkg::op_sltiu, 5'd1, 5'd22, 16'h8001),
                id_pkg::alu_sltu, 5'd22, 1'b1, 32'hffff_8001, 4'b0000);
    decode_case("andi", i_word(id_pkg::op_andi, 5'd1, 5'd23, 16'h8000),
                id_pkg::alu_and, 5'd23, 1'b1, 32'h0000_8000, 4'b0000);
    decode_case("ori", i_word(id_pkg::op_ori, 5'd1, 5'd24, 16'hf00f),
                id_pkg::alu_or, 5'd24, 1'b1, 32'h0000_f00f, 4'b0000);
    decode_case("xori", i_word(id_pkg::op_xori, 5'd1, 5'd25, 16'hc3c3),
                id_pkg::alu_xor, 5'd25, 1'b1, 32'h0000_c3c3, 4'b0000);
    decode_case("lui", i_word(id_pkg::op_lui, 5'd0, 5'd26, 16'h1234),
                id_pkg::alu_lui, 5'd26, 1'b1, 32'h0000_1234, 4'b0000);
    decode_case("lw", i_word(id_pkg::op_lw, 5'd1, 5'd27, 16'h0004),
                id_pkg::alu_add, 5'd27, 1'b1, 32'h0000_0004, 4'b0010);
    decode_case("sw", i_word(id_pkg::op_sw, 5'd1, 5'd28, 16'hfffc),
                id_pkg::alu_add, 5'd0, 1'b1, 32'hffff_fffc, 4'b0001);   // no writeback
endtask

task automatic rf_write_read();
    logic [31:0] v5;
    logic [31:0] v6;
    v5 = $random(seed);
    v6 = $random(seed);
    @(negedge clk);
    wb_dest   = 5'd5;
    wb_result = v5;
    @(negedge clk);
    wb_dest   = 5'd6;
    wb_result = v6;
    @(negedge clk);
    wb_dest   = 5'd0;
    wb_result = $random(seed);   // aimed at r0, must be dropped
    issue_inst(r_word(id_pkg::fn_addu, 5'd5, 5'd6, 5'd7, 5'd0), 32'h0000_0200);
    wait_out_valid();
    check_eq("rf_write_read", "rs_value", v5, out_rs_value);
    check_eq("rf_write_read", "rt_value", v6, out_rt_value);
    issue_inst(r_word(id_pkg::fn_addu, 5'd0, 5'd5, 5'd7, 5'd0), 32'h0000_0204);
    wait_out_valid();
    check_eq("rf_write_read", "r0 value", 32'h0, out_rs_value);
    check_eq("rf_write_read", "rt_value", v5, out_rt_value);
endtask

task automatic forward_priority();
    @(negedge clk);
    es_allowin = 1'b0;   // hold the instruction across the steps
    ex_dest    = 5'd9;
    mem_dest   = 5'd9;
    wb_dest    = 5'd9;
    ex_result  = $random(seed);
    mem_result = $random(seed);
    wb_result  = $random(seed);
    issue_inst(r_word(id_pkg::fn_or, 5'd9, 5'd9, 5'd3, 5'd0), 32'h0000_0300);
    wait_out_valid();
    // all three stages match, exe is newest
    check_eq("fwd_ex", "rs_value", ex_result, out_rs_value);
    check_eq("fwd_ex", "rt_value", ex_result, out_rt_value);
    @(negedge clk);
    ex_dest = 5'd0;
    #1;
    check_eq("fwd_mem", "rs_value", mem_result, out_rs_value);
    check_eq("fwd_mem", "rt_value", mem_result, out_rt_value);
    @(negedge clk);
    mem_dest  = 5'd0;
    wb_result = $random(seed);   // r9 still holds the older wb value
    #1;
    check_eq("fwd_wb", "rs_value", wb_result, out_rs_value);
    check_eq("fwd_wb", "rt_value", wb_result, out_rt_value);
    @(negedge clk);
    wb_dest    = 5'd0;
    es_allowin = 1'b1;
endtask

task automatic load_use_stall();
    @(negedge clk);
    ex_dest   = 5'd10;
    ex_load   = 1'b1;
    ex_result = $random(seed);
    issue_inst(r_word(id_pkg::fn_addu, 5'd10, 5'd2, 5'd3, 5'd0), 32'h0000_0500);
    check_eq("load_use", "out_valid", 32'd0, 32'(out_valid));
    check_eq("load_use", "allowin", 32'd0, 32'(allowin));
    @(negedge clk);
    #1;
    check_eq("load_use", "out_valid held", 32'd0, 32'(out_valid));
    @(negedge clk);
    ex_load = 1'b0;   // load data now in exe
    #1;
    check_eq("load_use", "out_valid", 32'd1, 32'(out_valid));
    check_eq("load_use", "rs_value", ex_result, out_rs_value);
    @(negedge clk);
    ex_load = 1'b1;
    // rt of addiu is its destination, not a source
    issue_inst(i_word(id_pkg::op_addiu, 5'd1, 5'd10, 16'h0001), 32'h0000_0504);
    check_eq("unused_rt", "out_valid", 32'd1, 32'(out_valid));
    check_eq("unused_rt", "allowin", 32'd1, 32'(allowin));
    @(negedge clk);
    ex_load = 1'b0;
    ex_dest = 5'd0;
endtask

task automatic exc_case(input string name, input logic [31:0] inst, input logic [4:0] code);
    issue_inst(inst, last_pc + 32'd4);
    wait_out_valid();
    check_eq(name, "exc", 32'd1, 32'(out_exc));
    check_eq(name, "exc_code", 32'(code), 32'(out_exc_code));
    if (code != 5'd10)
        check_eq(name, "dest", 32'd0, 32'(out_dest));
endtask

task automatic exception_codes();
    // code field filled, rd bits must not become a destination
    exc_case("syscall", r_word(id_pkg::fn_syscall, 5'd1, 5'd2, 5'd3, 5'd4), 5'd8);
    exc_case("break", r_word(id_pkg::fn_break, 5'd5, 5'd6, 5'd7, 5'd8), 5'd9);
    exc_case("undefined", 32'hfc00_0000, 5'd10);
endtask

task automatic backpressure_flush();
    @(negedge clk);
    es_allowin = 1'b0;
    issue_inst(r_word(id_pkg::fn_and, 5'd1, 5'd2, 5'd3, 5'd0), 32'h0000_0400);
    wait_out_valid();
    @(negedge clk);
    in_valid = 1'b1;   // second instruction waits upstream
    in_inst  = r_word(id_pkg::fn_or, 5'd1, 5'd2, 5'd4, 5'd0);
    in_pc    = 32'h0000_0404;
    repeat (3) begin
        @(negedge clk);
        #1;
        check_eq("backpressure", "out_pc", 32'h0000_0400, out_pc);
        check_eq("backpressure", "out_valid", 32'd1, 32'(out_valid));
        check_eq("backpressure", "allowin", 32'd0, 32'(allowin));
    end
    @(negedge clk);
    es_allowin = 1'b1;
    @(negedge clk);
    in_valid   = 1'b0;
    es_allowin = 1'b0;
    #1;
    check_eq("release", "out_pc", 32'h0000_0404, out_pc);
    check_eq("release", "out_valid", 32'd1, 32'(out_valid));
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush      = 1'b0;
    es_allowin = 1'b1;
    #1;
    check_eq("flush", "out_valid", 32'd0, 32'(out_valid));
    check_eq("flush", "allowin", 32'd1, 32'(allowin));
endtask

`endif

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module tb_id_stage;
    localparam int CYCLE_LIMIT = 2000;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic [`ID_XLEN-1:0]    in_inst;
    logic [`ID_XLEN-1:0]    in_pc;
    logic                   allowin;
    logic                   es_allowin;
    logic                   out_valid;
    logic [`ID_XLEN-1:0]    out_pc;
    logic [3:0]             out_alu_op;
    logic [`ID_XLEN-1:0]    out_rs_value;
    logic [`ID_XLEN-1:0]    out_rt_value;
    logic [`ID_XLEN-1:0]    out_imm_value;
    logic                   out_src1_is_sa;
    logic                   out_src2_is_imm;
    logic                   out_load_op;
    logic                   out_mem_we;
    logic                   out_ovf_check;
    logic [`ID_RADDR_W-1:0] out_dest;
    logic                   out_exc;
    logic [4:0]             out_exc_code;
    logic [`ID_RADDR_W-1:0] ex_dest;
    logic [`ID_XLEN-1:0]    ex_result;
    logic                   ex_load;
    logic [`ID_RADDR_W-1:0] mem_dest;
    logic [`ID_XLEN-1:0]    mem_result;
    logic                   mem_load;
    logic [`ID_RADDR_W-1:0] wb_dest;
    logic [`ID_XLEN-1:0]    wb_result;
    logic                   flush;

    integer              seed;
    int                  error_count;
    int                  check_count;
    int                  cycle_count;
    logic [`ID_XLEN-1:0] last_pc;   // pc of the most recent issue

    id_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // r-type word from fields
    function automatic logic [31:0] r_word(input id_pkg::funct_e funct, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa);
        return {id_pkg::op_special, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] i_word(input id_pkg::opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_eq(input string test, input string field,
                            input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("Error: %s %s expected %h actual %h", test, field, exp, act);
        end
    endtask

    // present one instruction upstream until the stage takes it
    task automatic issue_inst(input logic [31:0] inst, input logic [31:0] pc);
        @(negedge clk);
        while (!allowin) @(negedge clk);
        in_valid = 1'b1;
        in_inst  = inst;
        in_pc    = pc;
        last_pc  = pc;
        @(negedge clk);
        in_valid = 1'b0;
        #1;
    endtask

    task automatic wait_out_valid();
        while (!out_valid) begin
            @(negedge clk);
            #1;
        end
    endtask

    `include "id_tests.svh"

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("checks: %0d errors: %0d", check_count, error_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed        = 32'hb1ff_e099;
        error_count = 0;
        check_count = 0;
        last_pc     = '0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_inst     = '0;
        in_pc       = '0;
        es_allowin  = 1'b1;
        ex_dest     = '0;
        ex_result   = '0;
        ex_load     = 1'b0;
        mem_dest    = '0;
        mem_result  = '0;
        mem_load    = 1'b0;
        wb_dest     = '0;
        wb_result   = '0;
        flush       = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_eq("reset", "out_valid", 32'd0, 32'(out_valid));
        check_eq("reset", "out_exc", 32'd0, 32'(out_exc));
        check_eq("reset", "allowin", 32'd1, 32'(allowin));

        decode_all();
        rf_write_read();
        forward_priority();
        load_use_stall();
        exception_codes();
        backpressure_flush();

        @(negedge clk);
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== hdl/id_stage.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   reset,
    // from fetch
    input  logic                   in_valid,
    input  logic [`ID_XLEN-1:0]    in_inst,
    input  logic [`ID_XLEN-1:0]    in_pc,
    output logic                   allowin,
    // to execute
    input  logic                   es_allowin,
    output logic                   out_valid,
    output logic [`ID_XLEN-1:0]    out_pc,
    output logic [3:0]             out_alu_op,
    output logic [`ID_XLEN-1:0]    out_rs_value,
    output logic [`ID_XLEN-1:0]    out_rt_value,
    output logic [`ID_XLEN-1:0]    out_imm_value,
    output logic                   out_src1_is_sa,
    output logic                   out_src2_is_imm,
    output logic                   out_load_op,
    output logic                   out_mem_we,
    output logic                   out_ovf_check,
    output logic [`ID_RADDR_W-1:0] out_dest,
    output logic                   out_exc,
    output logic [4:0]             out_exc_code,
    // bypass from later stages
    input  logic [`ID_RADDR_W-1:0] ex_dest,
    input  logic [`ID_XLEN-1:0]    ex_result,
    input  logic                   ex_load,
    input  logic [`ID_RADDR_W-1:0] mem_dest,
    input  logic [`ID_XLEN-1:0]    mem_result,
    input  logic                   mem_load,
    input  logic [`ID_RADDR_W-1:0] wb_dest,
    input  logic [`ID_XLEN-1:0]    wb_result,
    input  logic                   flush
);
    id_pkg::dec_ctrl_t ctrl;

    stage_if   u_stage_if (.clk(clk));
    rf_read_if u_rf_if ();

    id_pipe_reg u_pipe_reg (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_pc      (in_pc),
        .flush      (flush),
        .es_allowin (es_allowin),
        .allowin    (allowin),
        .out_valid  (out_valid),
        .st         (u_stage_if.pipe)
    );

    inst_decoder u_decoder (
        .st        (u_stage_if.dec),
        .ctrl      (ctrl),
        .imm_value (out_imm_value)
    );

    operand_bypass u_bypass (
        .st         (u_stage_if.hazard),
        .rf         (u_rf_if.reader),
        .uses_rs    (ctrl.uses_rs),
        .uses_rt    (ctrl.uses_rt),
        .ex_dest    (ex_dest),
        .mem_dest   (mem_dest),
        .wb_dest    (wb_dest),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .ex_load    (ex_load),
        .mem_load   (mem_load),
        .rs_value   (out_rs_value),
        .rt_value   (out_rt_value)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .wb_dest   (wb_dest),
        .wb_result (wb_result),
        .rf        (u_rf_if.regs)
    );

    assign out_pc          = u_stage_if.pc;
    assign out_alu_op      = ctrl.alu_op;
    assign out_src1_is_sa  = ctrl.src1_is_sa;
    assign out_src2_is_imm = ctrl.src2_is_imm;
    assign out_load_op     = ctrl.load_op;
    assign out_mem_we      = ctrl.mem_we;
    assign out_ovf_check   = ctrl.ovf_check;
    assign out_dest        = ctrl.dest;
    assign out_exc         = (ctrl.exc != id_pkg::exc_none);
    assign out_exc_code    = ctrl.exc;

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`ID_RADDR_W-1:0] wb_dest,
    input  logic [`ID_XLEN-1:0]    wb_result,
    rf_read_if.regs                rf
);
    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ID_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_dest != '0) begin   // writes to r0 are dropped
            regs[wb_dest] <= wb_result;
        end
    end

    // async read, r0 hardwired
    assign rf.rs_data = (rf.rs_addr == '0) ? '0 : regs[rf.rs_addr];
    assign rf.rt_data = (rf.rt_addr == '0) ? '0 : regs[rf.rt_addr];

    a_r0_zero: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

// ==== hdl/operand_bypass.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module operand_bypass (
    stage_if.hazard                st,
    rf_read_if.reader              rf,
    input  logic                   uses_rs,
    input  logic                   uses_rt,
    input  logic [`ID_RADDR_W-1:0] ex_dest,
    input  logic [`ID_RADDR_W-1:0] mem_dest,
    input  logic [`ID_RADDR_W-1:0] wb_dest,
    input  logic [`ID_XLEN-1:0]    ex_result,
    input  logic [`ID_XLEN-1:0]    mem_result,
    input  logic [`ID_XLEN-1:0]    wb_result,
    input  logic                   ex_load,
    input  logic                   mem_load,
    output logic [`ID_XLEN-1:0]    rs_value,
    output logic [`ID_XLEN-1:0]    rt_value
);
    id_pkg::inst_u          inst;
    logic [`ID_RADDR_W-1:0] rs;
    logic [`ID_RADDR_W-1:0] rt;
    logic                   rs_used;
    logic                   rt_used;

    // newest producer wins, ex before mem before wb
    function automatic logic [`ID_XLEN-1:0] pick_value(
        input logic                   used,
        input logic [`ID_RADDR_W-1:0] addr,
        input logic [`ID_XLEN-1:0]    rf_data
    );
        if (!used)
            return rf_data;
        if (addr == ex_dest)
            return ex_result;
        if (addr == mem_dest)
            return mem_result;
        if (addr == wb_dest)
            return wb_result;
        return rf_data;
    endfunction

    // load result not available yet
    function automatic logic load_pending(
        input logic                   used,
        input logic [`ID_RADDR_W-1:0] addr
    );
        return used && ((ex_load && addr == ex_dest) || (mem_load && addr == mem_dest));
    endfunction

    assign inst       = st.inst;
    assign rs         = inst.r.rs;
    assign rt         = inst.r.rt;
    assign rf.rs_addr = rs;
    assign rf.rt_addr = rt;
    assign rs_used    = uses_rs && (rs != '0);   // r0 never forwarded
    assign rt_used    = uses_rt && (rt != '0);

    always_comb begin
        rs_value = pick_value(rs_used, rs, rf.rs_data);
        rt_value = pick_value(rt_used, rt, rf.rt_data);
        st.stall = st.valid && (load_pending(rs_used, rs) || load_pending(rt_used, rt));
    end

    a_stall_needs_valid: assert property (@(posedge st.clk)
        !st.valid |-> !st.stall);

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module inst_decoder (
    stage_if.dec                st,
    output id_pkg::dec_ctrl_t   ctrl,
    output logic [`ID_XLEN-1:0] imm_value
);
    id_pkg::inst_u inst;
    logic          legal;
    logic          sa_zero;
    logic          rs_zero;
    logic          imm_shift;

    assign inst      = st.inst;
    assign sa_zero   = (inst.r.sa == 5'd0);
    assign rs_zero   = (inst.r.rs == 5'd0);
    assign imm_shift = (inst.r.op == id_pkg::op_special) &&
                       (inst.r.funct inside {id_pkg::fn_sll, id_pkg::fn_srl, id_pkg::fn_sra});

    always_comb begin
        legal             = 1'b1;
        ctrl.alu_op       = id_pkg::alu_add;
        ctrl.src1_is_sa   = 1'b0;
        ctrl.src2_is_imm  = 1'b0;
        ctrl.imm_sign_ext = 1'b0;
        ctrl.uses_rs      = 1'b1;
        ctrl.uses_rt      = 1'b0;
        ctrl.load_op      = 1'b0;
        ctrl.mem_we       = 1'b0;
        ctrl.ovf_check    = 1'b0;
        ctrl.dest         = inst.i.rt;   // immediate forms write rt
        ctrl.exc          = id_pkg::exc_none;

        if (inst.r.op == id_pkg::op_special) begin
            ctrl.uses_rt = 1'b1;
            ctrl.dest    = inst.r.rd;
            legal        = sa_zero;     // register ops want sa clear
            case (inst.r.funct)
                id_pkg::fn_addu: ctrl.alu_op = id_pkg::alu_add;
                id_pkg::fn_subu: ctrl.alu_op = id_pkg::alu_sub;
                id_pkg::fn_add: begin
                    ctrl.alu_op    = id_pkg::alu_add;
                    ctrl.ovf_check = 1'b1;
                end
                id_pkg::fn_sub: begin
                    ctrl.alu_op    = id_pkg::alu_sub;
                    ctrl.ovf_check = 1'b1;
                end
                id_pkg::fn_slt:  ctrl.alu_op = id_pkg::alu_slt;
                id_pkg::fn_sltu: ctrl.alu_op = id_pkg::alu_sltu;
                id_pkg::fn_and:  ctrl.alu_op = id_pkg::alu_and;
                id_pkg::fn_or:   ctrl.alu_op = id_pkg::alu_or;
                id_pkg::fn_xor:  ctrl.alu_op = id_pkg::alu_xor;
                id_pkg::fn_nor:  ctrl.alu_op = id_pkg::alu_nor;
                id_pkg::fn_sll,
                id_pkg::fn_sllv: ctrl.alu_op = id_pkg::alu_sll;
                id_pkg::fn_srl,
                id_pkg::fn_srlv: ctrl.alu_op = id_pkg::alu_srl;
                id_pkg::fn_sra,
                id_pkg::fn_srav: ctrl.alu_op = id_pkg::alu_sra;
                id_pkg::fn_syscall: begin
                    legal    = 1'b1;    // code field is don't care
                    ctrl.exc = id_pkg::exc_sys;
                end
                id_pkg::fn_break: begin
                    legal    = 1'b1;
                    ctrl.exc = id_pkg::exc_bp;
                end
                default: legal = 1'b0;
            endcase

            // sll/srl/sra take sa instead of rs
            if (imm_shift) begin
                legal           = rs_zero;
                ctrl.uses_rs    = 1'b0;
                ctrl.src1_is_sa = 1'b1;
            end

            if (ctrl.exc != id_pkg::exc_none) begin
                ctrl.dest    = '0;
                ctrl.uses_rs = 1'b0;
                ctrl.uses_rt = 1'b0;
            end
        end else begin
            ctrl.src2_is_imm  = 1'b1;
            ctrl.imm_sign_ext = 1'b1;
            case (inst.i.op)
                id_pkg::op_addiu: ctrl.alu_op = id_pkg::alu_add;
                id_pkg::op_addi: begin
                    ctrl.alu_op    = id_pkg::alu_add;
                    ctrl.ovf_check = 1'b1;
                end
                id_pkg::op_slti:  ctrl.alu_op = id_pkg::alu_slt;
                id_pkg::op_sltiu: ctrl.alu_op = id_pkg::alu_sltu;   // still sign extended
                id_pkg::op_andi: begin
                    ctrl.alu_op       = id_pkg::alu_and;
                    ctrl.imm_sign_ext = 1'b0;
                end
                id_pkg::op_ori: begin
                    ctrl.alu_op       = id_pkg::alu_or;
                    ctrl.imm_sign_ext = 1'b0;
                end
                id_pkg::op_xori: begin
                    ctrl.alu_op       = id_pkg::alu_xor;
                    ctrl.imm_sign_ext = 1'b0;
                end
                id_pkg::op_lui: begin
                    legal             = rs_zero;
                    ctrl.alu_op       = id_pkg::alu_lui;
                    ctrl.imm_sign_ext = 1'b0;
                    ctrl.uses_rs      = 1'b0;
                end
                id_pkg::op_lw:    ctrl.load_op = 1'b1;
                id_pkg::op_sw: begin
                    ctrl.mem_we  = 1'b1;
                    ctrl.uses_rt = 1'b1;    // store data
                    ctrl.dest    = '0;
                end
                default: legal = 1'b0;
            endcase
        end

        // reserved instruction, strip every side effect
        if (!legal) begin
            ctrl.exc       = id_pkg::exc_ri;
            ctrl.dest      = '0;
            ctrl.load_op   = 1'b0;
            ctrl.mem_we    = 1'b0;
            ctrl.ovf_check = 1'b0;
            ctrl.uses_rs   = 1'b0;
            ctrl.uses_rt   = 1'b0;
        end
    end

    // shift amount rides on the immediate bus
    assign imm_value = ctrl.src1_is_sa
                     ? {{(`ID_XLEN-5){1'b0}}, inst.r.sa}
                     : {{(`ID_XLEN-16){ctrl.imm_sign_ext & inst.i.imm[15]}}, inst.i.imm};

endmodule

// ==== hdl/id_pipe_reg.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_pipe_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  logic [`ID_XLEN-1:0] in_inst,
    input  logic [`ID_XLEN-1:0] in_pc,
    input  logic                flush,
    input  logic                es_allowin,
    output logic                allowin,
    output logic                out_valid,
    stage_if.pipe               st
);
    logic take;

    // empty stage, or current one leaves this cycle
    assign allowin   = !st.valid || (!st.stall && es_allowin);
    assign out_valid = st.valid && !st.stall;
    assign take      = in_valid && allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            st.valid <= 1'b0;
        end else if (flush) begin
            st.valid <= 1'b0;   // drop whatever is held or arriving
        end else if (allowin) begin
            st.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st.inst <= id_pkg::inst_u'(`ID_NOP);
        end else if (take) begin
            st.inst <= id_pkg::inst_u'(in_inst);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            st.pc <= in_pc;
        end
    end

    a_out_valid_held: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> st.valid);

    // back-pressure must freeze the held instruction
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (st.valid && !es_allowin) |=> ($stable(st.inst) && $stable(st.pc)));

endmodule

// ==== hdl/id_ifs.sv ====
`timescale 1ns/1ps
`include "id_cfg.svh"

// held instruction of the decode stage
interface stage_if (
    input logic clk
);
    logic                valid;
    id_pkg::inst_u       inst;
    logic [`ID_XLEN-1:0] pc;
    logic                stall;   // load-use hazard, hold the stage

    modport pipe (
        output valid, inst, pc,
        input  stall
    );

    modport dec (
        input inst, pc
    );

    // clk only for the hazard checks
    modport hazard (
        input  clk, valid, inst,
        output stall
    );
endinterface

// two combinational register file read ports
interface rf_read_if;
    logic [`ID_RADDR_W-1:0] rs_addr;
    logic [`ID_RADDR_W-1:0] rt_addr;
    logic [`ID_XLEN-1:0]    rs_data;
    logic [`ID_XLEN-1:0]    rt_data;

    modport reader (output rs_addr, rt_addr, input rs_data, rt_data);
    modport regs (input rs_addr, rt_addr, output rs_data, rt_data);
endinterface

// ==== hdl/id_pkg.sv ====
`include "id_cfg.svh"

package id_pkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special opcode
    typedef enum logic [5:0] {
        fn_sll     = 6'h00,
        fn_srl     = 6'h02,
        fn_sra     = 6'h03,
        fn_sllv    = 6'h04,
        fn_srlv    = 6'h06,
        fn_srav    = 6'h07,
        fn_syscall = 6'h0c,
        fn_break   = 6'h0d,
        fn_add     = 6'h20,
        fn_addu    = 6'h21,
        fn_sub     = 6'h22,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_xor     = 6'h26,
        fn_nor     = 6'h27,
        fn_slt     = 6'h2a,
        fn_sltu    = 6'h2b
    } funct_e;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        funct_e      funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // mips cause register exccode values
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10
    } exc_code_e;

    typedef struct packed {
        alu_op_e                alu_op;
        logic                   src1_is_sa;   // shift amount from sa field
        logic                   src2_is_imm;
        logic                   imm_sign_ext;
        logic                   uses_rs;
        logic                   uses_rt;
        logic                   load_op;
        logic                   mem_we;
        logic                   ovf_check;    // add, addi, sub trap on overflow
        logic [`ID_RADDR_W-1:0] dest;         // zero means no writeback
        exc_code_e              exc;
    } dec_ctrl_t;

endpackage

// ==== include/id_cfg.svh ====
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// datapath and pc width
`define ID_XLEN     32

// register file geometry
`define ID_RADDR_W  5
`define ID_NUM_REGS 32

// empty instruction register decodes as sll r0, r0, 0
`define ID_NOP      32'h0000_0000

`endif
